//--- include/lsu_sys_consts.svh
`ifndef LSU_SYS_CONSTS_SVH
`define LSU_SYS_CONSTS_SVH

`define DEV_CLINT      32'h0200_0000  // timer region
`define DEV_CLINT_END  32'h0200_FFFF
`define CLINT_MTIME_LO 16'hBFF8       // offsets inside the timer region
`define CLINT_MTIME_HI 16'hBFFC

`define SRAM_BASE      32'h8000_0000
`define SRAM_WORDS     256            // depth in words

`define MASK_NONE      2'd0           // access size codes
`define MASK_BYTE      2'd1
`define MASK_HALF      2'd2
`define MASK_WORD      2'd3

`endif

//--- rtl/lsu_sys_pkg.sv
package lsu_sys_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;  // byte address
    typedef logic [3:0]  strb_t;  // one bit per byte lane
    typedef logic [1:0]  size_t;  // MASK_* codes

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        logic  ready;
        logic  rvalid;  // one-cycle response that also acks writes
        word_t rdata;
        logic  err;
    } bus_rsp_t;

    typedef enum logic [1:0] {IDLE, REQ, WAIT, DONE} lsu_state_t;

    typedef enum logic [1:0] {
        IFU_IDLE = 2'd0,
        IFU_REQ  = 2'd1,
        IFU_WAIT = 2'd2
    } ifu_state_t;

endpackage

//--- rtl/lsu.sv
`timescale 1ns/1ps
`include "lsu_sys_consts.svh"

module lsu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  ready,
    input  logic                  wen,
    input  logic                  ren,
    input  logic                  sign,
    input  lsu_sys_pkg::size_t    mask,
    input  lsu_sys_pkg::addr_t    addr,
    input  lsu_sys_pkg::word_t    wdata,
    output lsu_sys_pkg::bus_req_t bus_req,
    input  lsu_sys_pkg::bus_rsp_t bus_rsp,
    output lsu_sys_pkg::word_t    rdata,
    output logic                  valid,
    output logic                  err
);
    import lsu_sys_pkg::*;

    lsu_state_t state_q;
    logic       write_q;
    logic       sign_q;
    size_t      mask_q;
    addr_t      addr_q;
    word_t      wdata_q;
    word_t      rdata_q;
    logic       err_q;
    strb_t      lanes;
    logic [4:0] lane_shift;
    word_t      rshift;
    word_t      rext;

    assign lane_shift = {addr_q[1:0], 3'b000};  // 8 * byte offset

    always_comb begin
        case (mask_q)
            `MASK_BYTE: lanes = strb_t'(4'b0001 << addr_q[1:0]);
            `MASK_HALF: lanes = addr_q[1] ? 4'b1100 : 4'b0011;
            `MASK_WORD: lanes = 4'b1111;
            default:    lanes = 4'b0000;
        endcase
    end

    always_comb begin
        bus_req.valid = (state_q == REQ);
        bus_req.write = write_q;
        bus_req.addr  = addr_q;
        bus_req.wdata = wdata_q << lane_shift;
        bus_req.strb  = write_q ? lanes : 4'b0000;
    end

    // bring the addressed bytes down to lane 0, then extend
    assign rshift = bus_rsp.rdata >> lane_shift;

    always_comb begin
        case (mask_q)
            `MASK_BYTE: rext = {{24{rshift[7] & sign_q}}, rshift[7:0]};
            `MASK_HALF: rext = {{16{rshift[15] & sign_q}}, rshift[15:0]};
            `MASK_WORD: rext = rshift;
            default:    rext = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (ready && (wen || ren)) state_q <= REQ;
                REQ:  if (bus_rsp.ready) state_q <= WAIT;  // accepted
                WAIT: begin
                    if (bus_rsp.rvalid) begin
                        state_q <= DONE;
                        err_q   <= bus_rsp.err;
                    end
                end
                default: state_q <= IDLE;  // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && ready && (wen || ren)) begin
            write_q <= wen;
            sign_q  <= sign;
            mask_q  <= mask;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state_q == WAIT && bus_rsp.rvalid) begin
            rdata_q <= write_q ? '0 : rext;
        end
    end

    assign rdata = rdata_q;
    assign err   = err_q;

    // without a memory op the pulse just echoes ready
    assign valid = (wen || ren) ? (state_q == DONE) : ready;

endmodule

//--- rtl/ifu.sv
`timescale 1ns/1ps

module ifu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  fetch,
    input  lsu_sys_pkg::addr_t    pc,
    output lsu_sys_pkg::bus_req_t bus_req,
    input  lsu_sys_pkg::bus_rsp_t bus_rsp,
    output lsu_sys_pkg::word_t    inst,
    output logic                  inst_valid,
    output logic                  inst_err
);
    import lsu_sys_pkg::*;

    ifu_state_t state_q;
    addr_t      pc_q;
    word_t      inst_q;
    logic       inst_valid_q;
    logic       inst_err_q;

    always_comb begin
        bus_req.valid = (state_q == IFU_REQ);
        bus_req.write = 1'b0;
        bus_req.addr  = pc_q;
        bus_req.wdata = '0;
        bus_req.strb  = 4'b0000;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= IFU_IDLE;
            inst_valid_q <= 1'b0;
            inst_err_q   <= 1'b0;
        end else begin
            inst_valid_q <= 1'b0;
            case (state_q)
                IFU_IDLE: if (fetch) state_q <= IFU_REQ;  // busy fetches dropped
                IFU_REQ:  if (bus_rsp.ready) state_q <= IFU_WAIT;
                IFU_WAIT: begin
                    if (bus_rsp.rvalid) begin
                        state_q      <= IFU_IDLE;
                        inst_valid_q <= 1'b1;
                        inst_err_q   <= bus_rsp.err;
                    end
                end
                default: state_q <= IFU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IFU_IDLE && fetch) pc_q <= pc;
        if (state_q == IFU_WAIT && bus_rsp.rvalid) inst_q <= bus_rsp.rdata;
    end

    assign inst       = inst_q;
    assign inst_valid = inst_valid_q;
    assign inst_err   = inst_err_q;

endmodule

//--- rtl/bus_interconnect.sv
`timescale 1ns/1ps
`include "lsu_sys_consts.svh"

module bus_interconnect (
    input  logic                  clk,
    input  logic                  arst_n,
    input  lsu_sys_pkg::bus_req_t lsu_req,
    input  lsu_sys_pkg::bus_req_t ifu_req,
    output lsu_sys_pkg::bus_rsp_t lsu_rsp,
    output lsu_sys_pkg::bus_rsp_t ifu_rsp,
    output lsu_sys_pkg::bus_req_t sram_req,
    input  lsu_sys_pkg::bus_rsp_t sram_rsp,
    output lsu_sys_pkg::bus_req_t clint_req,
    input  lsu_sys_pkg::bus_rsp_t clint_rsp
);
    import lsu_sys_pkg::*;

    typedef enum logic [1:0] {TGT_SRAM, TGT_CLINT, TGT_ERR} tgt_t;

    logic     busy_q;   // bus owned
    logic     acc_q;    // accepted, response due
    logic     owner_q;  // 1 = ifu
    tgt_t     sel_q;
    logic     granted;
    bus_req_t win_req;
    bus_req_t own_req;
    bus_rsp_t tgt_rsp;
    bus_rsp_t err_rsp;
    bus_rsp_t rsp_out;

    function automatic tgt_t decode(addr_t a);
        if (a >= `DEV_CLINT && a <= `DEV_CLINT_END) return TGT_CLINT;
        if (a >= `SRAM_BASE && a < (`SRAM_BASE + `SRAM_WORDS * 4)) return TGT_SRAM;
        return TGT_ERR;
    endfunction

    assign win_req = lsu_req.valid ? lsu_req : ifu_req;  // lsu first
    assign own_req = owner_q ? ifu_req : lsu_req;
    assign granted = busy_q && !acc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            acc_q   <= 1'b0;
            owner_q <= 1'b0;
            sel_q   <= TGT_ERR;
        end else if (!busy_q) begin
            if (lsu_req.valid || ifu_req.valid) begin
                busy_q  <= 1'b1;
                owner_q <= !lsu_req.valid;
                sel_q   <= decode(win_req.addr);
            end
        end else if (!acc_q) begin
            if (own_req.valid && tgt_rsp.ready) acc_q <= 1'b1;
        end else begin
            busy_q <= 1'b0;  // response cycle frees the bus
            acc_q  <= 1'b0;
        end
    end

    always_comb begin
        err_rsp.ready  = 1'b1;
        err_rsp.rvalid = acc_q;
        err_rsp.rdata  = '0;
        err_rsp.err    = 1'b1;
        case (sel_q)
            TGT_SRAM:  tgt_rsp = sram_rsp;
            TGT_CLINT: tgt_rsp = clint_rsp;
            default:   tgt_rsp = err_rsp;
        endcase
    end

    always_comb begin
        sram_req        = own_req;
        sram_req.valid  = granted && own_req.valid && (sel_q == TGT_SRAM);
        clint_req       = own_req;
        clint_req.valid = granted && own_req.valid && (sel_q == TGT_CLINT);
    end

    always_comb begin
        rsp_out.ready  = granted && tgt_rsp.ready;
        rsp_out.rvalid = acc_q && tgt_rsp.rvalid;
        rsp_out.rdata  = tgt_rsp.rdata;
        rsp_out.err    = tgt_rsp.err;
    end

    assign lsu_rsp = owner_q ? '0 : rsp_out;
    assign ifu_rsp = owner_q ? rsp_out : '0;

endmodule

//--- rtl/data_sram.sv
`timescale 1ns/1ps
`include "lsu_sys_consts.svh"

module data_sram (
    input  logic                  clk,
    input  logic                  arst_n,
    input  lsu_sys_pkg::bus_req_t req,
    output lsu_sys_pkg::bus_rsp_t rsp
);
    import lsu_sys_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    word_t            mem [`SRAM_WORDS];
    logic [IDX_W-1:0] idx;
    word_t            rdata_q;
    logic             rvalid_q;

    assign idx = req.addr[IDX_W+1:2];  // word index

    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.strb[b]) begin
                        mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req.valid;  // always ready
        end
    end

    always_comb begin
        rsp.ready  = 1'b1;
        rsp.rvalid = rvalid_q;
        rsp.rdata  = rdata_q;
        rsp.err    = 1'b0;
    end

endmodule

//--- rtl/clint.sv
`timescale 1ns/1ps
`include "lsu_sys_consts.svh"

module clint (
    input  logic                  clk,
    input  logic                  arst_n,
    input  lsu_sys_pkg::bus_req_t req,
    output lsu_sys_pkg::bus_rsp_t rsp
);
    import lsu_sys_pkg::*;

    logic [63:0] mtime_q;
    logic        rvalid_q;
    logic        err_q;
    word_t       rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime_q  <= '0;
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            mtime_q  <= mtime_q + 64'd1;  // free running
            rvalid_q <= req.valid;
            if (req.valid) err_q <= req.write;  // read only
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            case (req.addr[15:0])
                `CLINT_MTIME_LO: rdata_q <= req.write ? '0 : mtime_q[31:0];
                `CLINT_MTIME_HI: rdata_q <= req.write ? '0 : mtime_q[63:32];
                default:         rdata_q <= '0;
            endcase
        end
    end

    always_comb begin
        rsp.ready  = 1'b1;
        rsp.rvalid = rvalid_q;
        rsp.rdata  = rdata_q;
        rsp.err    = err_q;
    end

endmodule

//--- rtl/lsu_sys_top.sv
`timescale 1ns/1ps

module lsu_sys_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               ready,
    input  logic               wen,
    input  logic               ren,
    input  logic               sign,
    input  lsu_sys_pkg::size_t mask,
    input  lsu_sys_pkg::addr_t addr,
    input  lsu_sys_pkg::word_t wdata,
    input  logic               fetch,
    input  lsu_sys_pkg::addr_t pc,
    output lsu_sys_pkg::word_t rdata,
    output logic               valid,
    output logic               err,
    output lsu_sys_pkg::word_t inst,
    output logic               inst_valid,
    output logic               inst_err
);
    import lsu_sys_pkg::*;

    bus_req_t lsu_req;
    bus_rsp_t lsu_rsp;
    bus_req_t ifu_req;
    bus_rsp_t ifu_rsp;
    bus_req_t sram_req;
    bus_rsp_t sram_rsp;
    bus_req_t clint_req;
    bus_rsp_t clint_rsp;

    lsu i_lsu (
        .clk(clk), .arst_n(arst_n), .ready(ready), .wen(wen), .ren(ren),
        .sign(sign), .mask(mask), .addr(addr), .wdata(wdata),
        .bus_req(lsu_req), .bus_rsp(lsu_rsp),
        .rdata(rdata), .valid(valid), .err(err)
    );

    ifu i_ifu (
        .clk(clk), .arst_n(arst_n), .fetch(fetch), .pc(pc),
        .bus_req(ifu_req), .bus_rsp(ifu_rsp),
        .inst(inst), .inst_valid(inst_valid), .inst_err(inst_err)
    );

    bus_interconnect i_bus_interconnect (
        .clk(clk), .arst_n(arst_n),
        .lsu_req(lsu_req), .ifu_req(ifu_req),
        .lsu_rsp(lsu_rsp), .ifu_rsp(ifu_rsp),
        .sram_req(sram_req), .sram_rsp(sram_rsp),
        .clint_req(clint_req), .clint_rsp(clint_rsp)
    );

    data_sram i_data_sram (.clk(clk), .arst_n(arst_n), .req(sram_req), .rsp(sram_rsp));

    clint i_clint (.clk(clk), .arst_n(arst_n), .req(clint_req), .rsp(clint_rsp));

endmodule

//--- verif/lsu_sys_tb.sv
`timescale 1ns/1ps
`include "lsu_sys_consts.svh"

module lsu_sys_tb;
    import lsu_sys_pkg::*;

    logic  clk;
    logic  arst_n;
    logic  ready;
    logic  wen;
    logic  ren;
    logic  sign;
    size_t mask;
    addr_t addr;
    word_t wdata;
    logic  fetch;
    addr_t pc;
    word_t rdata;
    logic  valid;
    logic  err;
    word_t inst;
    logic  inst_valid;
    logic  inst_err;

    integer     seed;
    logic       started;        // first ready strobe given
    logic       chk_data;       // compare rdata on this access
    logic       exp_err;
    word_t      exp_rdata;
    word_t      exp_inst;
    logic [7:0] shadow [1024];  // byte image of the SRAM

    lsu_sys_top i_lsu_sys_top (
        .clk(clk), .arst_n(arst_n), .ready(ready), .wen(wen), .ren(ren),
        .sign(sign), .mask(mask), .addr(addr), .wdata(wdata),
        .fetch(fetch), .pc(pc),
        .rdata(rdata), .valid(valid), .err(err),
        .inst(inst), .inst_valid(inst_valid), .inst_err(inst_err)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input word_t expd, input word_t act);
        $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expd, act);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    startup_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !started |-> (!valid && !err && !inst_valid))
        else report_mismatch("{valid,err,inst_valid}", 32'h0,
                             word_t'({$sampled(valid), $sampled(err), $sampled(inst_valid)}));

    passthrough: assert property (@(posedge clk) disable iff (!arst_n)
        (!wen && !ren) |-> (valid == ready))
        else report_mismatch("valid", word_t'($sampled(ready)), word_t'($sampled(valid)));

    load_data: assert property (@(posedge clk) disable iff (!arst_n)
        (valid && (wen || ren) && chk_data) |-> (rdata == exp_rdata))
        else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));

    access_err: assert property (@(posedge clk) disable iff (!arst_n)
        (valid && (wen || ren)) |-> (err == exp_err))
        else report_mismatch("err", word_t'($sampled(exp_err)), word_t'($sampled(err)));

    fetch_data: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid |-> (inst == exp_inst))
        else report_mismatch("inst", $sampled(exp_inst), $sampled(inst));

    fetch_err: assert property (@(posedge clk) disable iff (!arst_n)
        inst_valid |-> !inst_err)
        else report_mismatch("inst_err", 32'h0, word_t'($sampled(inst_err)));

    function automatic int access_bytes(input size_t m);
        case (m)
            `MASK_BYTE: return 1;
            `MASK_HALF: return 2;
            default:    return 4;
        endcase
    endfunction

    function automatic word_t fill_pattern(input addr_t a);
        return a ^ 32'h3C5A_96E1;
    endfunction

    function automatic addr_t random_addr(input size_t m);
        int unsigned r;
        addr_t       a;
        r = $unsigned($random(seed));
        a = `SRAM_BASE + (r & 32'h7F);  // first 32 words only
        return a & ~addr_t'(access_bytes(m) - 1);
    endfunction

    // little-endian bytes from the image, extended to a word
    function automatic word_t expect_load(input addr_t a, input size_t m, input logic s);
        logic [9:0] bi;
        word_t      v;
        int         nb;
        nb = access_bytes(m);
        bi = a[9:0];
        v  = '0;
        for (int i = 0; i < nb; i++) begin
            v  = v | (word_t'(shadow[bi]) << (8 * i));
            bi = bi + 10'd1;
        end
        if (s && nb < 4 && ((v >> (8 * nb - 1)) & 32'd1) == 32'd1) begin
            v = v | (32'hFFFF_FFFF << (8 * nb));
        end
        return v;
    endfunction

    task automatic shadow_store(input addr_t a, input size_t m, input word_t d);
        logic [9:0] bi;
        word_t      v;
        bi = a[9:0];
        v  = d;
        for (int i = 0; i < access_bytes(m); i++) begin
            shadow[bi] = v[7:0];
            bi = bi + 10'd1;
            v  = v >> 8;
        end
    endtask

    task automatic lsu_access(input logic is_write, input size_t m, input logic s,
                              input addr_t a, input word_t d, input logic check,
                              input word_t e_data, input logic e_err, output word_t rd);
        int n;
        @(negedge clk);
        exp_rdata = e_data;
        exp_err   = e_err;
        chk_data  = check;
        started   = 1'b1;
        ready     = 1'b1;
        wen       = is_write;
        ren       = !is_write;
        mask      = m;
        sign      = s;
        addr      = a;
        wdata     = d;
        @(negedge clk);
        ready = 1'b0;  // wen/ren stay up until the pulse
        n = 0;
        while (!valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!valid) abort_run("lsu valid pulse never came");
        rd = rdata;
        @(negedge clk);
        wen = 1'b0;
        ren = 1'b0;
    endtask

    // lsu load and ifu fetch requested in the same cycle
    task automatic fetch_with_load(input addr_t pc_a, input addr_t ld_a);
        int n;
        int v_at;
        int i_at;
        v_at = -1;
        i_at = -1;
        @(negedge clk);
        exp_inst  = expect_load(pc_a, `MASK_WORD, 1'b0);
        exp_rdata = expect_load(ld_a, `MASK_WORD, 1'b0);
        exp_err   = 1'b0;
        chk_data  = 1'b1;
        fetch     = 1'b1;
        pc        = pc_a;
        ready     = 1'b1;
        ren       = 1'b1;
        mask      = `MASK_WORD;
        sign      = 1'b0;
        addr      = ld_a;
        @(negedge clk);
        fetch = 1'b0;
        ready = 1'b0;
        n = 0;
        while ((v_at < 0 || i_at < 0) && n < 20) begin
            @(negedge clk);
            n++;
            if (valid && v_at < 0) v_at = n;
            if (inst_valid && i_at < 0) i_at = n;
        end
        if (v_at < 0 || i_at < 0) abort_run("valid or inst_valid pulse never came");
        @(negedge clk);
        ren = 1'b0;
        assert (v_at <= i_at) else abort_run("inst_valid came before valid");
    endtask

    initial begin
        addr_t       a;
        word_t       d;
        word_t       rd;
        word_t       t0;
        word_t       t1;
        size_t       m;
        logic        s;
        int unsigned r;
        seed      = 32'he61e;
        clk       = 1'b0;
        arst_n    = 1'b0;
        ready     = 1'b0;
        wen       = 1'b0;
        ren       = 1'b0;
        sign      = 1'b0;
        mask      = `MASK_NONE;
        addr      = '0;
        wdata     = '0;
        fetch     = 1'b0;
        pc        = '0;
        started   = 1'b0;
        chk_data  = 1'b0;
        exp_err   = 1'b0;
        exp_rdata = '0;
        exp_inst  = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);  // quiet window before any strobe

        for (int k = 0; k < 8; k++) begin  // valid echoes ready without a memory op
            r       = $unsigned($random(seed));
            started = 1'b1;
            ready   = r[0];
            @(negedge clk);
        end
        ready = 1'b0;

        for (int w = 0; w < 32; w++) begin
            a = `SRAM_BASE + addr_t'(4 * w);
            lsu_access(1'b1, `MASK_WORD, 1'b0, a, fill_pattern(a), 1'b0, '0, 1'b0, rd);
            shadow_store(a, `MASK_WORD, fill_pattern(a));
        end

        for (int k = 0; k < 40; k++) begin
            r = $unsigned($random(seed));
            m = size_t'(r % 3 + 1);
            a = random_addr(m);
            d = $random(seed);
            lsu_access(1'b1, m, 1'b0, a, d, 1'b0, '0, 1'b0, rd);
            shadow_store(a, m, d);
        end

        for (int k = 0; k < 60; k++) begin  // every size with both sign values
            m = size_t'(k % 3 + 1);
            s = ((k / 3) % 2) == 1;
            a = random_addr(m);
            lsu_access(1'b0, m, s, a, '0, 1'b1, expect_load(a, m, s), 1'b0, rd);
        end

        a = `DEV_CLINT + addr_t'(`CLINT_MTIME_LO);
        lsu_access(1'b0, `MASK_WORD, 1'b0, a, '0, 1'b0, '0, 1'b0, t0);
        repeat (5) @(negedge clk);
        lsu_access(1'b0, `MASK_WORD, 1'b0, a, '0, 1'b0, '0, 1'b0, t1);
        assert (t1 > t0) else report_mismatch("mtime_lo", t0, t1);
        lsu_access(1'b1, `MASK_WORD, 1'b0, a, 32'h1234_5678, 1'b0, '0, 1'b1, rd);

        lsu_access(1'b0, `MASK_WORD, 1'b0, 32'h4000_0000, '0, 1'b1, 32'h0, 1'b1, rd);

        fetch_with_load(random_addr(`MASK_WORD), random_addr(`MASK_WORD));

        repeat (2) @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- lsu_sys.f
+incdir+include
rtl/lsu_sys_pkg.sv
rtl/lsu.sv
rtl/ifu.sv
rtl/bus_interconnect.sv
rtl/data_sram.sv
rtl/clint.sv
rtl/lsu_sys_top.sv
verif/lsu_sys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the lsu_sys testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module lsu_sys_tb \
    -f lsu_sys.f \
    -o lsu_sys_sim

./obj_dir/lsu_sys_sim 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
